// File: hw/ysyx_22050710_exu.sv
// Execute unit; selects ALU operands, runs the ALU and forms the writeback and store records.
`timescale 1ns/1ns
`default_nettype none

`include "ysyx_22050710_macros.svh"

module ysyx_22050710_exu (
  input  ysyx_22050710_pkg::ctrl_t  i_ctrl,
  input  logic [`YSYX_XLEN-1:0]     i_pc,
  input  logic [`YSYX_XLEN-1:0]     i_rdata_a,
  input  logic [`YSYX_XLEN-1:0]     i_rdata_b,
  input  logic                      i_active,
  output ysyx_22050710_pkg::wb_t    o_wb,
  output ysyx_22050710_pkg::store_t o_store
);

  logic [`YSYX_XLEN-1:0] op_a;
  logic [`YSYX_XLEN-1:0] op_b;
  logic [`YSYX_XLEN-1:0] alu_out;

  assign op_a = i_ctrl.a_is_pc ? i_pc : i_rdata_a;

  always_comb begin
    case (i_ctrl.b_sel)
      2'b00:   op_b = i_rdata_b;
      2'b01:   op_b = i_ctrl.imm;
      default: op_b = `YSYX_XLEN'(4);
    endcase
  end

  // halt and unknown opcodes produce nothing.
  always_comb begin
    case (i_ctrl.alu_op)
      ysyx_22050710_pkg::ALU_ADD:    alu_out = op_a + op_b;
      ysyx_22050710_pkg::ALU_COPY_B: alu_out = op_b;
      default:                       alu_out = '0;
    endcase
  end

  always_comb begin
    o_wb.valid    = i_ctrl.reg_wen & i_active;
    o_wb.rd       = i_ctrl.rd;
    o_wb.data     = alu_out;
    // Store address comes out of the adder, data is rs2.
    o_store.valid = i_ctrl.mem_wen & i_active;
    o_store.addr  = alu_out;
    o_store.data  = i_rdata_b;
  end

endmodule

`default_nettype wire

// File: hw/ysyx_22050710_idu.sv
// Instruction decoder; turns one instruction word into the control record for execute.
`timescale 1ns/1ns
`default_nettype none

`include "ysyx_22050710_macros.svh"

module ysyx_22050710_idu (
  input  ysyx_22050710_pkg::inst_t i_inst,
  output ysyx_22050710_pkg::ctrl_t o_ctrl
);

  logic [6:0] opcode;
  logic [2:0] funct3;

  logic inst_lui, inst_auipc, inst_jal, inst_jalr;
  logic inst_addi, inst_sd, inst_ebreak;
  logic type_i, type_u, type_s, type_j;

  logic [`YSYX_XLEN-1:0] imm_i, imm_u, imm_s, imm_j;
  logic [`YSYX_XLEN-1:0] imm;

  assign opcode = i_inst.r.opcode;
  assign funct3 = i_inst.r.funct3;

  assign inst_lui    = (opcode == `YSYX_OP_LUI);
  assign inst_auipc  = (opcode == `YSYX_OP_AUIPC);
  assign inst_jal    = (opcode == `YSYX_OP_JAL);
  assign inst_jalr   = (opcode == `YSYX_OP_JALR) && (funct3 == `YSYX_F3_JALR);
  assign inst_addi   = (opcode == `YSYX_OP_IMM) && (funct3 == `YSYX_F3_ADDI);
  assign inst_sd     = (opcode == `YSYX_OP_STORE) && (funct3 == `YSYX_F3_SD);
  // ebreak is the one fully fixed encoding.
  assign inst_ebreak = (opcode == `YSYX_OP_SYSTEM) && (funct3 == `YSYX_F3_PRIV) &&
                       (i_inst.i.imm == `YSYX_IMM_EBREAK) &&
                       (i_inst.i.rs1 == 5'd0) && (i_inst.i.rd == 5'd0);

  assign type_i = inst_addi | inst_jalr | inst_ebreak;
  assign type_u = inst_lui | inst_auipc;
  assign type_s = inst_sd;
  assign type_j = inst_jal;

  // Sign-extended immediates, one per format.
  assign imm_i = {{(`YSYX_XLEN-12){i_inst.i.imm[11]}}, i_inst.i.imm};
  assign imm_u = {{(`YSYX_XLEN-32){i_inst.u.imm_31_12[19]}}, i_inst.u.imm_31_12, 12'b0};
  assign imm_s = {{(`YSYX_XLEN-12){i_inst.s.imm_11_5[6]}}, i_inst.s.imm_11_5,
                  i_inst.s.imm_4_0};
  assign imm_j = {{(`YSYX_XLEN-21){i_inst.j.imm_20}}, i_inst.j.imm_20, i_inst.j.imm_19_12,
                  i_inst.j.imm_11, i_inst.j.imm_10_1, 1'b0};

  always_comb begin
    imm = '0;
    case (1'b1)
      type_i:  imm = imm_i;
      type_u:  imm = imm_u;
      type_s:  imm = imm_s;
      type_j:  imm = imm_j;
      default: imm = '0;
    endcase
  end

  always_comb begin
    o_ctrl.reg_wen     = inst_lui | inst_auipc | inst_jal | inst_jalr | inst_addi;
    // Operand A is the PC for pc-relative results and links.
    o_ctrl.a_is_pc     = inst_auipc | inst_jal | inst_jalr;
    o_ctrl.b_sel       = {inst_jal | inst_jalr, inst_lui | inst_auipc | inst_addi | inst_sd};
    o_ctrl.pc_jump     = inst_jal | inst_jalr;
    o_ctrl.pc_base_reg = inst_jalr;
    o_ctrl.mem_wen     = inst_sd;
    o_ctrl.halt        = inst_ebreak;
    o_ctrl.imm         = imm;
    o_ctrl.ra          = i_inst.r.rs1;
    o_ctrl.rb          = i_inst.r.rs2;
    o_ctrl.rd          = i_inst.r.rd;
    if (inst_lui) begin
      o_ctrl.alu_op = ysyx_22050710_pkg::ALU_COPY_B;
    end else if (inst_auipc | inst_jal | inst_jalr | inst_addi | inst_sd) begin
      o_ctrl.alu_op = ysyx_22050710_pkg::ALU_ADD;
    end else if (inst_ebreak) begin
      o_ctrl.alu_op = ysyx_22050710_pkg::ALU_HALT;
    end else begin
      o_ctrl.alu_op = ysyx_22050710_pkg::ALU_NONE;
    end
  end

endmodule

`default_nettype wire

// File: hw/ysyx_22050710_ifu.sv
// Fetch unit; holds the program counter and the halted flag and computes the next PC.
`timescale 1ns/1ns
`default_nettype none

`include "ysyx_22050710_macros.svh"

module ysyx_22050710_ifu (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_halt,
  input  logic                  i_jump,
  input  logic                  i_base_reg,
  input  logic [`YSYX_XLEN-1:0] i_rs1,
  input  logic [`YSYX_XLEN-1:0] i_imm,
  output logic [`YSYX_XLEN-1:0] o_pc,
  output logic                  o_halted
);

  logic [`YSYX_XLEN-1:0] base;
  logic [`YSYX_XLEN-1:0] target;
  logic [`YSYX_XLEN-1:0] pc_next;

  assign base   = i_base_reg ? i_rs1 : o_pc;
  assign target = base + i_imm;

  // Jump targets drop bit 0.
  assign pc_next = i_jump ? {target[`YSYX_XLEN-1:1], 1'b0} : o_pc + `YSYX_XLEN'(4);

  // The PC stays on the ebreak once it has been seen.
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_pc     <= `YSYX_RESET_PC;
      o_halted <= 1'b0;
    end else if (!o_halted) begin
      if (i_halt) begin
        o_halted <= 1'b1;
      end else begin
        o_pc <= pc_next;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/ysyx_22050710_macros.svh
// Width, reset vector and opcode constants shared by the core RTL and its testbench.
`ifndef YSYX_22050710_MACROS_SVH
`define YSYX_22050710_MACROS_SVH

`define YSYX_XLEN      64
`define YSYX_RESET_PC  64'h0000_0000_8000_0000

// Major opcodes.
`define YSYX_OP_LUI    7'b0110111
`define YSYX_OP_AUIPC  7'b0010111
`define YSYX_OP_JAL    7'b1101111
`define YSYX_OP_JALR   7'b1100111
`define YSYX_OP_IMM    7'b0010011
`define YSYX_OP_STORE  7'b0100011
`define YSYX_OP_SYSTEM 7'b1110011

// Minor opcodes.
`define YSYX_F3_ADDI   3'b000
`define YSYX_F3_JALR   3'b000
`define YSYX_F3_SD     3'b011
`define YSYX_F3_PRIV   3'b000
`define YSYX_IMM_EBREAK 12'h001

`endif

// File: hw/ysyx_22050710_pkg.sv
// Shared types for the core: instruction formats, decoder control and result records.
`default_nettype none

`include "ysyx_22050710_macros.svh"

package ysyx_22050710_pkg;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_r_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_i_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } inst_s_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } inst_b_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_u_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_j_t;

  // One instruction word, seen through each encoding format.
  typedef union packed {
    inst_r_t r;
    inst_i_t i;
    inst_s_t s;
    inst_b_t b;
    inst_u_t u;
    inst_j_t j;
  } inst_t;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'b0000,
    ALU_COPY_B = 4'b0011,
    ALU_HALT   = 4'b1110,
    ALU_NONE   = 4'b1111
  } alu_op_e;

  // b_sel: 00 is rs2, 01 is the immediate, 10 is the constant 4.
  typedef struct packed {
    logic                  reg_wen;
    logic                  a_is_pc;
    logic [1:0]            b_sel;
    alu_op_e               alu_op;
    logic                  pc_jump;
    logic                  pc_base_reg;
    logic                  mem_wen;
    logic                  halt;
    logic [`YSYX_XLEN-1:0] imm;
    logic [4:0]            ra;
    logic [4:0]            rb;
    logic [4:0]            rd;
  } ctrl_t;

  typedef struct packed {
    logic                  valid;
    logic [4:0]            rd;
    logic [`YSYX_XLEN-1:0] data;
  } wb_t;

  typedef struct packed {
    logic                  valid;
    logic [`YSYX_XLEN-1:0] addr;
    logic [`YSYX_XLEN-1:0] data;
  } store_t;

endpackage

`default_nettype wire

// File: hw/ysyx_22050710_regfile.sv
// General register file with two combinational read ports and one write port.
`timescale 1ns/1ns
`default_nettype none

`include "ysyx_22050710_macros.svh"

module ysyx_22050710_regfile (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  ysyx_22050710_pkg::wb_t i_wb,
  input  logic [4:0]             i_ra,
  input  logic [4:0]             i_rb,
  output logic [`YSYX_XLEN-1:0]  o_rdata_a,
  output logic [`YSYX_XLEN-1:0]  o_rdata_b
);

  // x0 has no storage.
  logic [`YSYX_XLEN-1:0] regs [1:31];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int k = 1; k < 32; k++) begin
        regs[k] <= '0;
      end
    end else if (i_wb.valid && (i_wb.rd != 5'd0)) begin
      regs[i_wb.rd] <= i_wb.data;
    end
  end

  assign o_rdata_a = (i_ra == 5'd0) ? '0 : regs[i_ra];
  assign o_rdata_b = (i_rb == 5'd0) ? '0 : regs[i_rb];

endmodule

`default_nettype wire

// File: hw/ysyx_22050710_top.sv
// Single-cycle core top; wires fetch, decode, register file and execute to the memory ports.
`timescale 1ns/1ns
`default_nettype none

`include "ysyx_22050710_macros.svh"

module ysyx_22050710_top (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic [31:0]               i_inst,
  output logic [`YSYX_XLEN-1:0]     o_pc,
  output ysyx_22050710_pkg::wb_t    o_wb,
  output ysyx_22050710_pkg::store_t o_store,
  output logic                      o_halted
);

  ysyx_22050710_pkg::inst_t inst;
  ysyx_22050710_pkg::ctrl_t ctrl;

  logic [`YSYX_XLEN-1:0] rdata_a;
  logic [`YSYX_XLEN-1:0] rdata_b;
  logic                  active;

  assign inst = i_inst;

  // Results count only while out of reset and not halted.
  assign active = i_rst_n & ~o_halted;

  ysyx_22050710_idu u_idu (
    .i_inst (inst),
    .o_ctrl (ctrl)
  );

  ysyx_22050710_ifu u_ifu (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_halt     (ctrl.halt),
    .i_jump     (ctrl.pc_jump),
    .i_base_reg (ctrl.pc_base_reg),
    .i_rs1      (rdata_a),
    .i_imm      (ctrl.imm),
    .o_pc       (o_pc),
    .o_halted   (o_halted)
  );

  ysyx_22050710_regfile u_regfile (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_wb      (o_wb),
    .i_ra      (ctrl.ra),
    .i_rb      (ctrl.rb),
    .o_rdata_a (rdata_a),
    .o_rdata_b (rdata_b)
  );

  ysyx_22050710_exu u_exu (
    .i_ctrl    (ctrl),
    .i_pc      (o_pc),
    .i_rdata_a (rdata_a),
    .i_rdata_b (rdata_b),
    .i_active  (active),
    .o_wb      (o_wb),
    .o_store   (o_store)
  );

endmodule

`default_nettype wire

// File: test/tb_ysyx_22050710_top.sv
// Testbench for the single-cycle core; runs a seeded random program against a reference step model.
`timescale 1ns/1ns
`default_nettype none

`include "ysyx_22050710_macros.svh"

module tb_ysyx_22050710_top;

  localparam int IMG_WORDS   = 256;
  localparam int CYCLE_LIMIT = IMG_WORDS * 2 + 20;

  // Expected outcome of one instruction.
  typedef struct packed {
    logic [`YSYX_XLEN-1:0]     next_pc;
    ysyx_22050710_pkg::wb_t    wb;
    ysyx_22050710_pkg::store_t st;
    logic                      halt;
  } step_t;

  logic                      clk;
  logic                      rst_n;
  logic [31:0]               inst;
  logic [`YSYX_XLEN-1:0]     dut_pc;
  ysyx_22050710_pkg::wb_t    dut_wb;
  ysyx_22050710_pkg::store_t dut_store;
  logic                      dut_halted;

  logic [31:0]           image [IMG_WORDS];
  logic [`YSYX_XLEN-1:0] model_regs [32];
  logic [`YSYX_XLEN-1:0] model_pc;
  integer                seed;
  int                    cycles = 0;

  ysyx_22050710_top uut (
    .i_clk    (clk),
    .i_rst_n  (rst_n),
    .i_inst   (inst),
    .o_pc     (dut_pc),
    .o_wb     (dut_wb),
    .o_store  (dut_store),
    .o_halted (dut_halted)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "Run stopped at the first error.");
  endtask

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("Mismatch %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // Instruction encoders, straight from the base ISA formats.
  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], `YSYX_OP_STORE};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `YSYX_OP_JAL};
  endfunction

  function automatic string op_name(input logic [31:0] w);
    if (w == 32'h0010_0073) begin
      return "ebreak";
    end
    case (w[6:0])
      `YSYX_OP_LUI:   return "lui";
      `YSYX_OP_AUIPC: return "auipc";
      `YSYX_OP_JAL:   return "jal";
      `YSYX_OP_JALR:  return (w[14:12] == 3'd0) ? "jalr" : "unknown";
      `YSYX_OP_IMM:   return (w[14:12] == 3'd0) ? "addi" : "unknown";
      `YSYX_OP_STORE: return (w[14:12] == 3'd3) ? "sd" : "unknown";
      default:        return "unknown";
    endcase
  endfunction

  function automatic step_t ref_step(input logic [63:0] regs [32], input logic [63:0] pc,
                                     input logic [31:0] w);
    step_t       s;
    logic [63:0] imm_i;
    logic [63:0] imm_s;
    logic [63:0] imm_u;
    logic [63:0] imm_j;
    logic [63:0] rs1_val;
    logic [63:0] rs2_val;
    s       = '0;
    imm_i   = {{52{w[31]}}, w[31:20]};
    imm_s   = {{52{w[31]}}, w[31:25], w[11:7]};
    imm_u   = {{32{w[31]}}, w[31:12], 12'b0};
    imm_j   = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    rs1_val = regs[w[19:15]];
    rs2_val = regs[w[24:20]];
    s.next_pc = pc + 64'd4;
    s.wb.rd   = w[11:7];
    case (op_name(w))
      "lui": begin
        s.wb.valid = 1'b1;
        s.wb.data  = imm_u;
      end
      "auipc": begin
        s.wb.valid = 1'b1;
        s.wb.data  = pc + imm_u;
      end
      "addi": begin
        s.wb.valid = 1'b1;
        s.wb.data  = rs1_val + imm_i;
      end
      "jal": begin
        s.wb.valid = 1'b1;
        s.wb.data  = pc + 64'd4;
        s.next_pc  = (pc + imm_j) & ~64'd1;
      end
      "jalr": begin
        s.wb.valid = 1'b1;
        s.wb.data  = pc + 64'd4;
        s.next_pc  = (rs1_val + imm_i) & ~64'd1;
      end
      "sd": begin
        s.st.valid = 1'b1;
        s.st.addr  = rs1_val + imm_s;
        s.st.data  = rs2_val;
      end
      "ebreak": begin
        s.halt    = 1'b1;
        s.next_pc = pc;
      end
      default: s.wb.rd = w[11:7];
    endcase
    return s;
  endfunction

  // Jumps only go forward and never land on the jalr of a pair.
  task automatic build_image();
    int          i;
    int          sel;
    int          t;
    logic [31:0] r;
    logic [4:0]  link;
    bit          hit [IMG_WORDS];
    foreach (hit[k]) hit[k] = 1'b0;
    i = 0;
    while (i < IMG_WORDS - 1) begin
      sel = $random(seed) & 31;
      r   = $random(seed);
      if (sel >= 9 && sel <= 11) begin
        image[i] = enc_u(r[31:12], r[11:7], `YSYX_OP_LUI);
      end else if (sel >= 12 && sel <= 14) begin
        image[i] = enc_u(r[31:12], r[11:7], `YSYX_OP_AUIPC);
      end else if (sel >= 15 && sel <= 19) begin
        image[i] = enc_s(r[31:20], r[24:20], r[19:15], 3'd3);
      end else if (sel == 20 || sel == 21) begin
        t = i + 1 + int'(r[2:0]);
        if (t > IMG_WORDS - 1) t = IMG_WORDS - 1;
        hit[t]   = 1'b1;
        image[i] = enc_j(21'((t - i) * 4), r[11:7]);
      end else if ((sel == 22 || sel == 23) && i < IMG_WORDS - 3 && !hit[i + 1]) begin
        // Link register gets this PC; jalr lands on a later word, sometimes with bit 0 set.
        link = 5'(r[3:0]) + 5'd1;
        t    = i + 2 + int'(r[7:4]);
        if (t > IMG_WORDS - 1) t = IMG_WORDS - 1;
        hit[t]       = 1'b1;
        image[i]     = enc_u(20'd0, link, `YSYX_OP_AUIPC);
        image[i + 1] = enc_i(12'((t - i) * 4 + int'(r[8])), link, 3'd0, r[11:7],
                             `YSYX_OP_JALR);
        i++;
      end else if (sel == 24) begin
        image[i] = {r[31:7], 7'b0110011};
      end else begin
        image[i] = enc_i(r[31:20], r[19:15], 3'd0, r[11:7], `YSYX_OP_IMM);
      end
      i++;
    end
    image[IMG_WORDS - 1] = enc_i(12'h001, 5'd0, 3'd0, 5'd0, `YSYX_OP_SYSTEM);
  endtask

  task automatic drive_fetch();
    logic [63:0] off;
    off = dut_pc - `YSYX_RESET_PC;
    if (off >= 64'(IMG_WORDS * 4) || off[1:0] != 2'b00) begin
      fail_run("PC left the program image");
    end else begin
      inst = image[int'(off >> 2)];
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    inst  = '0;
    seed  = 49078;
    build_image();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

  // Instruction memory answers every cycle.
  initial begin
    forever begin
      @(posedge clk);
      #1;
      drive_fetch();
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      fail_run("Timeout before halt");
    end
  end

  initial begin : compare_proc
    step_t       exp;
    string       name;
    logic [31:0] word;
    for (int k = 0; k < 32; k++) begin
      model_regs[k] = '0;
    end
    model_pc = `YSYX_RESET_PC;
    exp      = '0;
    @(negedge clk);
    while (!rst_n) begin
      check("reset pc", `YSYX_RESET_PC, dut_pc);
      check("reset halted", 64'd0, dut_halted);
      check("reset wb.valid", 64'd0, dut_wb.valid);
      check("reset store.valid", 64'd0, dut_store.valid);
      @(negedge clk);
    end
    while (!exp.halt) begin
      word = image[int'((model_pc - `YSYX_RESET_PC) >> 2)];
      name = op_name(word);
      check({name, " pc"}, model_pc, dut_pc);
      check({name, " halted"}, 64'd0, dut_halted);
      exp = ref_step(model_regs, model_pc, word);
      check({name, " wb.valid"}, exp.wb.valid, dut_wb.valid);
      if (exp.wb.valid) begin
        check({name, " wb.rd"}, exp.wb.rd, dut_wb.rd);
        check({name, " wb.data"}, exp.wb.data, dut_wb.data);
      end
      check({name, " store.valid"}, exp.st.valid, dut_store.valid);
      if (exp.st.valid) begin
        check({name, " store.addr"}, exp.st.addr, dut_store.addr);
        check({name, " store.data"}, exp.st.data, dut_store.data);
      end
      if (exp.wb.valid && exp.wb.rd != 5'd0) begin
        model_regs[exp.wb.rd] = exp.wb.data;
      end
      model_pc = exp.next_pc;
      @(negedge clk);
    end
    // Halt edge plus five more frozen cycles.
    for (int n = 0; n < 6; n++) begin
      check("halt halted", 64'd1, dut_halted);
      check("halt pc", model_pc, dut_pc);
      check("halt wb.valid", 64'd0, dut_wb.valid);
      check("halt store.valid", 64'd0, dut_store.valid);
      @(negedge clk);
    end
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: ysyx_22050710_top.f
+incdir+hw
hw/ysyx_22050710_pkg.sv
hw/ysyx_22050710_idu.sv
hw/ysyx_22050710_ifu.sv
hw/ysyx_22050710_regfile.sv
hw/ysyx_22050710_exu.sv
hw/ysyx_22050710_top.sv
test/tb_ysyx_22050710_top.sv
